// ==== src/uart_cmd_cfg.svh ====
`ifndef UART_CMD_CFG_SVH
`define UART_CMD_CFG_SVH

// ****************************************
// Link timing
// ****************************************

// Clocks per serial bit. 8 keeps simulation short
// For a 50 MHz clock at 115200 baud this becomes 434
`define UART_CLKS_PER_BIT 8

// Start, eight data bits, parity and stop
`define UART_FRAME_BITS 11

// ****************************************
// Command shape
// ****************************************

// Bytes per host command, sent high byte first
`define UART_CMD_BYTES 2

`endif

// ==== src/uart_cmd_pkg.sv ====
`default_nettype none

`include "uart_cmd_cfg.svh"

package uart_cmd_pkg;

  // ****************************************
  // Data widths
  // ****************************************

  typedef logic [`UART_CMD_BYTES*8-1:0] cmd_word_t;
  typedef logic [7:0] uart_byte_t;

  // Bit 0 is the start bit and goes out first
  typedef logic [`UART_FRAME_BITS-1:0] frame_t;

  typedef logic [3:0] bit_cnt_t;

  // Must hold the largest divisor in use (434)
  typedef logic [8:0] baud_cnt_t;

  typedef struct packed {
    logic       parity_err;
    uart_byte_t data;
  } rx_word_t;

  // ****************************************
  // State machines
  // ****************************************

  typedef enum logic [2:0] {
    split_idle,
    split_send_hi,
    split_wait_hi,
    split_send_lo,
    split_wait_lo
  } split_state_e;

  typedef enum logic [2:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_parity,
    rx_stop
  } rx_state_e;

endpackage

`default_nettype wire

// ==== src/uart_cmd_split.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_cmd_split (
  input  logic                    clk,
  input  logic                    rst_n,
  input  uart_cmd_pkg::cmd_word_t cmd_in,
  input  logic                    cmd_vld,
  output logic                    cmd_rdy,
  input  logic                    tx_done,
  output uart_cmd_pkg::uart_byte_t tx_byte,
  output logic                    tx_start
);

  uart_cmd_pkg::split_state_e state_q;
  uart_cmd_pkg::split_state_e state_d;
  uart_cmd_pkg::cmd_word_t    cmd_q;
  logic                       accept;

  // The host may only hand over a command while the link is idle
  assign cmd_rdy = (state_q == uart_cmd_pkg::split_idle);
  assign accept  = cmd_vld && cmd_rdy;

  // ****************************************
  // Command holding register
  // ****************************************

  // Captured once per command so later changes on cmd_in are ignored
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd_in;
    end
  end

  // ****************************************
  // Byte sequencing
  // ****************************************

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      uart_cmd_pkg::split_idle: begin
        if (accept) begin
          state_d = uart_cmd_pkg::split_send_hi;
        end
      end
      uart_cmd_pkg::split_send_hi: begin
        state_d = uart_cmd_pkg::split_wait_hi;
      end
      uart_cmd_pkg::split_wait_hi: begin
        if (tx_done) begin
          state_d = uart_cmd_pkg::split_send_lo;
        end
      end
      uart_cmd_pkg::split_send_lo: begin
        state_d = uart_cmd_pkg::split_wait_lo;
      end
      uart_cmd_pkg::split_wait_lo: begin
        if (tx_done) begin
          state_d = uart_cmd_pkg::split_idle;
        end
      end
      default: begin
        state_d = uart_cmd_pkg::split_idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= uart_cmd_pkg::split_idle;
    end else begin
      state_q <= state_d;
    end
  end

  // One start strobe per byte, each lasting a single cycle
  assign tx_start = (state_q == uart_cmd_pkg::split_send_hi) ||
                    (state_q == uart_cmd_pkg::split_send_lo);

  // High byte goes first
  always_comb begin
    if ((state_q == uart_cmd_pkg::split_send_hi) ||
        (state_q == uart_cmd_pkg::split_wait_hi)) begin
      tx_byte = cmd_q[15:8];
    end else begin
      tx_byte = cmd_q[7:0];
    end
  end

endmodule

`default_nettype wire

// ==== src/uart_tx_frame.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "uart_cmd_cfg.svh"

module uart_tx_frame (
  input  logic                     clk,
  input  logic                     rst_n,
  input  uart_cmd_pkg::uart_byte_t tx_byte,
  input  logic                     tx_start,
  output logic                     tx,
  output logic                     tx_done
);

  localparam uart_cmd_pkg::baud_cnt_t baud_last =
    uart_cmd_pkg::baud_cnt_t'(`UART_CLKS_PER_BIT - 1);
  localparam uart_cmd_pkg::bit_cnt_t bit_last =
    uart_cmd_pkg::bit_cnt_t'(`UART_FRAME_BITS - 1);

  uart_cmd_pkg::frame_t    frame;
  uart_cmd_pkg::frame_t    shift_q;
  uart_cmd_pkg::baud_cnt_t baud_cnt_q;
  uart_cmd_pkg::bit_cnt_t  bit_cnt_q;
  logic                    busy_q;
  logic                    bit_end;

  // Stop, odd parity, data LSB first, start in bit 0
  assign frame = {1'b1, ~^tx_byte, tx_byte, 1'b0};

  assign bit_end = busy_q && (baud_cnt_q == baud_last);

  // Last clock of the stop bit
  assign tx_done = bit_end && (bit_cnt_q == bit_last);

  // ****************************************
  // Shifter and bit timing
  // ****************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q     <= 1'b0;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
      shift_q    <= '1;
      tx         <= 1'b1;
    end else if (tx_start && !busy_q) begin
      busy_q     <= 1'b1;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
      tx         <= frame[0];
      shift_q    <= {1'b1, frame[`UART_FRAME_BITS-1:1]};
    end else if (busy_q) begin
      if (bit_end) begin
        baud_cnt_q <= '0;
        // Ones fill in from the top, so the line settles high after stop
        tx         <= shift_q[0];
        shift_q    <= {1'b1, shift_q[`UART_FRAME_BITS-1:1]};
        if (bit_cnt_q == bit_last) begin
          busy_q    <= 1'b0;
          bit_cnt_q <= '0;
        end else begin
          bit_cnt_q <= bit_cnt_q + 1'b1;
        end
      end else begin
        baud_cnt_q <= baud_cnt_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/uart_rx_frame.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "uart_cmd_cfg.svh"

module uart_rx_frame (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   rx,
  output uart_cmd_pkg::rx_word_t read_data,
  output logic                   read_rdy
);

  localparam uart_cmd_pkg::baud_cnt_t baud_last =
    uart_cmd_pkg::baud_cnt_t'(`UART_CLKS_PER_BIT - 1);
  localparam uart_cmd_pkg::baud_cnt_t baud_half =
    uart_cmd_pkg::baud_cnt_t'(`UART_CLKS_PER_BIT / 2 - 1);
  localparam uart_cmd_pkg::bit_cnt_t data_last = 4'd7;

  logic                      rx_meta;
  logic                      rx_sync;
  logic                      rx_prev;
  logic                      fall;
  uart_cmd_pkg::rx_state_e   state_q;
  uart_cmd_pkg::baud_cnt_t   baud_cnt_q;
  uart_cmd_pkg::bit_cnt_t    bit_cnt_q;
  uart_cmd_pkg::uart_byte_t  data_q;
  logic                      parity_q;

  // ****************************************
  // Input synchronizer
  // ****************************************

  // Idle line is high, so reset to high to avoid a false start edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall = rx_prev && !rx_sync;

  // ****************************************
  // Frame receiver
  // ****************************************

  always_ff @(posedge clk) begin
    if ((state_q == uart_cmd_pkg::rx_data) && (baud_cnt_q == baud_last)) begin
      data_q <= {rx_sync, data_q[7:1]};
    end
    if ((state_q == uart_cmd_pkg::rx_parity) && (baud_cnt_q == baud_last)) begin
      parity_q <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= uart_cmd_pkg::rx_idle;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
      read_rdy   <= 1'b0;
      read_data  <= '0;
    end else begin
      read_rdy <= 1'b0;
      unique case (state_q)
        uart_cmd_pkg::rx_idle: begin
          baud_cnt_q <= '0;
          bit_cnt_q  <= '0;
          if (fall) begin
            state_q <= uart_cmd_pkg::rx_start;
          end
        end
        uart_cmd_pkg::rx_start: begin
          if (baud_cnt_q == baud_half) begin
            baud_cnt_q <= '0;
            // A line back high at mid start bit was only a glitch
            if (rx_sync) begin
              state_q <= uart_cmd_pkg::rx_idle;
            end else begin
              state_q <= uart_cmd_pkg::rx_data;
            end
          end else begin
            baud_cnt_q <= baud_cnt_q + 1'b1;
          end
        end
        uart_cmd_pkg::rx_data: begin
          if (baud_cnt_q == baud_last) begin
            baud_cnt_q <= '0;
            bit_cnt_q  <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == data_last) begin
              state_q <= uart_cmd_pkg::rx_parity;
            end
          end else begin
            baud_cnt_q <= baud_cnt_q + 1'b1;
          end
        end
        uart_cmd_pkg::rx_parity: begin
          if (baud_cnt_q == baud_last) begin
            baud_cnt_q <= '0;
            state_q    <= uart_cmd_pkg::rx_stop;
          end else begin
            baud_cnt_q <= baud_cnt_q + 1'b1;
          end
        end
        uart_cmd_pkg::rx_stop: begin
          if (baud_cnt_q == baud_last) begin
            state_q <= uart_cmd_pkg::rx_idle;
            // A low stop bit is a framing error and the byte is dropped
            if (rx_sync) begin
              read_data.data       <= data_q;
              read_data.parity_err <= ~(^{parity_q, data_q});
              read_rdy             <= 1'b1;
            end
          end else begin
            baud_cnt_q <= baud_cnt_q + 1'b1;
          end
        end
        default: begin
          state_q <= uart_cmd_pkg::rx_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/uart_cmd.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_cmd (
  input  logic                    clk,
  input  logic                    rst_n,
  input  uart_cmd_pkg::cmd_word_t cmd_in,
  input  logic                    cmd_vld,
  output logic                    cmd_rdy,
  input  logic                    rx,
  output logic                    tx,
  output uart_cmd_pkg::rx_word_t  read_data,
  output logic                    read_rdy
);

  uart_cmd_pkg::uart_byte_t tx_byte;
  logic                     tx_start;
  logic                     tx_done;

  // ****************************************
  // Transmit path
  // ****************************************

  uart_cmd_split uart_cmd_split_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .tx_done  (tx_done),
    .tx_byte  (tx_byte),
    .tx_start (tx_start)
  );

  uart_tx_frame uart_tx_frame_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_byte  (tx_byte),
    .tx_start (tx_start),
    .tx       (tx),
    .tx_done  (tx_done)
  );

  // ****************************************
  // Receive path
  // ****************************************

  // Runs on its own and shares nothing with the transmit side
  uart_rx_frame uart_rx_frame_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .read_data (read_data),
    .read_rdy  (read_rdy)
  );

endmodule

`default_nettype wire

// ==== verification/uart_cmd_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "uart_cmd_cfg.svh"

module uart_cmd_checker (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   tx,
  input  logic                   cmd_vld,
  input  logic                   cmd_rdy,
  input  uart_cmd_pkg::rx_word_t read_data,
  input  logic                   read_rdy,
  input  logic [18:0]            exp_row,
  input  logic                   test_start,
  input  logic                   test_end,
  output int                     pass_cnt,
  output int                     fail_cnt
);

  localparam int cpb = `UART_CLKS_PER_BIT;

  typedef struct packed {
    logic        is_cmd;
    logic [15:0] value;
    logic        par_bad;
    logic        stop_bad;
  } row_t;

  uart_cmd_pkg::uart_byte_t tx_q[$];
  uart_cmd_pkg::rx_word_t   rd_q[$];
  int                       dec_errs = 0;
  int                       acc_errs = 0;
  logic                     started = 1'b0;
  logic                     counting = 1'b0;
  int                       acc_cnt = 0;

  // ****************************************
  // Independent tx decoder
  // ****************************************

  initial begin : tx_decode
    logic [10:0] bits;
    forever begin
      @(negedge tx);
      repeat (cpb / 2) @(posedge clk);
      for (int i = 0; i < `UART_FRAME_BITS; i++) begin
        bits[i] = tx;
        if (i < `UART_FRAME_BITS - 1) begin
          repeat (cpb) @(posedge clk);
        end
      end
      if (bits[0] != 1'b0 || bits[10] != 1'b1 || ^bits[9:1] != 1'b1) begin
        $display("[ERROR] %0t: bad tx frame %b (start, parity or stop)", $time, bits);
        dec_errs++;
      end
      tx_q.push_back(bits[8:1]);
    end
  end

  always @(posedge clk) begin
    if (rst_n && read_rdy) begin
      rd_q.push_back(read_data);
    end
  end

  // Idle levels after reset, then the acceptance to ready timing
  always @(posedge clk) begin
    if (test_start) begin
      started = 1'b1;
    end
    if (rst_n && !started && (!tx || !cmd_rdy || read_rdy)) begin
      $display("[ERROR] %0t: idle levels wrong after reset", $time);
      acc_errs++;
    end
    if (counting) begin
      acc_cnt++;
      if (cmd_rdy) begin
        counting = 1'b0;
        if (acc_cnt != 2 * `UART_FRAME_BITS * cpb + 3) begin
          $display("[ERROR] %0t: cmd_rdy back after %0d cycles", $time, acc_cnt);
          acc_errs++;
        end
      end
    end else if (rst_n && cmd_vld && cmd_rdy) begin
      counting = 1'b1;
      acc_cnt  = 0;
    end
  end

  // ****************************************
  // Per-test comparison
  // ****************************************

  // Errors seen since the previous test ended are charged to the next one
  row_t                   row;
  int                     tx_base;
  int                     rd_base;
  int                     dec_base = 0;
  int                     acc_base = 0;
  int                     test_num = 0;
  uart_cmd_pkg::rx_word_t rd_before;

  initial begin
    pass_cnt = 0;
    fail_cnt = 0;
  end

  always @(posedge clk) begin : evaluate
    int own;
    uart_cmd_pkg::uart_byte_t hi;
    uart_cmd_pkg::uart_byte_t lo;
    if (test_start) begin
      row       = exp_row;
      tx_base   = tx_q.size();
      rd_base   = rd_q.size();
      rd_before = read_data;
      test_num++;
    end
    if (test_end) begin
      own = 0;
      hi  = row.value[15:8];
      lo  = row.value[7:0];
      if (row.is_cmd) begin
        if (tx_q.size() - tx_base != 2 || rd_q.size() - rd_base != 2) begin
          $display("Test %0d expected two frames each way but saw %0d sent, %0d received",
                   test_num, tx_q.size() - tx_base, rd_q.size() - rd_base);
          own++;
        end else begin
          if (tx_q[tx_base] != hi || tx_q[tx_base + 1] != lo) begin
            $display("[ERROR] %0t: tx bytes %h %h, expected %h %h", $time,
                     tx_q[tx_base], tx_q[tx_base + 1], hi, lo);
            own++;
          end
          if (rd_q[rd_base] != {1'b0, hi} || rd_q[rd_base + 1] != {1'b0, lo}) begin
            $display("[ERROR] %0t: loopback words %h %h, expected %h %h", $time,
                     rd_q[rd_base], rd_q[rd_base + 1], {1'b0, hi}, {1'b0, lo});
            own++;
          end
        end
      end else if (tx_q.size() != tx_base) begin
        $display("Test %0d saw tx frames during an rx-only test", test_num);
        own++;
      end else if (row.stop_bad) begin
        if (rd_q.size() != rd_base || read_data != rd_before) begin
          $display("[ERROR] %0t: frame with low stop bit was not dropped", $time);
          own++;
        end
      end else if (rd_q.size() - rd_base != 1) begin
        $display("Test %0d expected one received byte", test_num);
        own++;
      end else if (rd_q[rd_base] != {row.par_bad, lo}) begin
        $display("[ERROR] %0t: read_data %h, expected %h", $time,
                 rd_q[rd_base], {row.par_bad, lo});
        own++;
      end
      own      = own + (dec_errs - dec_base) + (acc_errs - acc_base);
      dec_base = dec_errs;
      acc_base = acc_errs;
      if (own == 0) begin
        pass_cnt++;
        $display("Test %0d value %h: ok", test_num, row.value);
      end else begin
        fail_cnt++;
        $display("Test %0d value %h: %0d errors", test_num, row.value, own);
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/uart_cmd_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "uart_cmd_cfg.svh"

module uart_cmd_sva (
  input logic clk,
  input logic rst_n,
  input logic cmd_vld,
  input logic cmd_rdy,
  input logic tx,
  input logic read_rdy
);

  // Both frames plus the gap cycle and the return to idle
  localparam int busy_cycles = 2 * `UART_FRAME_BITS * `UART_CLKS_PER_BIT + 2;

  int busy_left;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_left <= 0;
    end else if (cmd_vld && cmd_rdy) begin
      busy_left <= busy_cycles;
    end else if (busy_left != 0) begin
      busy_left <= busy_left - 1;
    end
  end

  rdy_low_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (busy_left != 0) |-> !cmd_rdy)
    else $error("cmd_rdy high while a command is still being sent");

  read_rdy_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy)
    else $error("read_rdy held high for more than one cycle");

  tx_idle_when_ready: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_rdy |-> tx)
    else $error("tx low while the command port is idle");

endmodule

bind uart_cmd uart_cmd_sva uart_cmd_sva_inst (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .tx       (tx),
  .read_rdy (read_rdy)
);

`default_nettype wire

// ==== verification/uart_cmd_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "uart_cmd_cfg.svh"

module uart_cmd_tb;

  localparam int cpb   = `UART_CLKS_PER_BIT;
  localparam int rows  = 11;
  localparam int limit = rows * (24 * cpb + 10) * 2;

  typedef struct packed {
    logic        is_cmd;
    logic [15:0] value;
    logic        par_bad;
    logic        stop_bad;
  } row_t;

  logic                    clk;
  logic                    rst_n;
  uart_cmd_pkg::cmd_word_t cmd_in;
  logic                    cmd_vld;
  logic                    cmd_rdy;
  logic                    rx;
  logic                    tx;
  uart_cmd_pkg::rx_word_t  read_data;
  logic                    read_rdy;
  logic                    loop_sel;
  logic                    rx_gen;
  logic                    test_start;
  logic                    test_end;
  row_t                    cur_row;
  row_t                    stim [rows];
  logic [31:0]             seed;
  int                      pass_cnt;
  int                      fail_cnt;

  // Loopback for commands, local frame source for rx-only tests
  assign rx = loop_sel ? tx : rx_gen;

  uart_cmd uart_cmd_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_data (read_data),
    .read_rdy  (read_rdy)
  );

  uart_cmd_checker checker_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .tx         (tx),
    .cmd_vld    (cmd_vld),
    .cmd_rdy    (cmd_rdy),
    .read_data  (read_data),
    .read_rdy   (read_rdy),
    .exp_row    (cur_row),
    .test_start (test_start),
    .test_end   (test_end),
    .pass_cnt   (pass_cnt),
    .fail_cnt   (fail_cnt)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic send_frame(input uart_cmd_pkg::uart_byte_t b, input logic par_bad,
                            input logic stop_bad);
    logic [10:0] f;
    f = {~stop_bad, (~^b) ^ par_bad, b, 1'b0};
    for (int i = 0; i < `UART_FRAME_BITS; i++) begin
      @(posedge clk);
      rx_gen <= f[i];
      repeat (cpb - 1) @(posedge clk);
    end
    @(posedge clk);
    rx_gen <= 1'b1;
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ****************************************
  // Watchdog
  // ****************************************

  initial begin
    repeat (limit) @(posedge clk);
    $display("Timeout: tests did not finish within %0d cycles", limit);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // ****************************************
  // Stimulus
  // ****************************************

  initial begin
    rst_n      = 1'b0;
    cmd_in     = '0;
    cmd_vld    = 1'b0;
    loop_sel   = 1'b0;
    rx_gen     = 1'b1;
    test_start = 1'b0;
    test_end   = 1'b0;
    cur_row    = '0;
    stim[0]  = '{1'b1, 16'h0000, 1'b0, 1'b0};
    stim[1]  = '{1'b1, 16'hFFFF, 1'b0, 1'b0};
    stim[2]  = '{1'b1, 16'hA55A, 1'b0, 1'b0};
    stim[3]  = '{1'b1, 16'h8001, 1'b0, 1'b0};
    seed = 32'd38;
    for (int i = 4; i < 8; i++) begin
      seed    = lcg_next(seed);
      stim[i] = '{1'b1, seed[31:16], 1'b0, 1'b0};
    end
    stim[8]  = '{1'b0, 16'h0035, 1'b1, 1'b0};
    stim[9]  = '{1'b0, 16'h00C3, 1'b0, 1'b1};
    stim[10] = '{1'b0, 16'h005A, 1'b0, 1'b0};
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    repeat (4) @(posedge clk);
    for (int r = 0; r < rows; r++) begin
      @(posedge clk);
      cur_row    <= stim[r];
      test_start <= 1'b1;
      @(posedge clk);
      test_start <= 1'b0;
      if (stim[r].is_cmd) begin
        loop_sel <= 1'b1;
        cmd_in   <= stim[r].value;
        cmd_vld  <= 1'b1;
        @(posedge clk);
        cmd_vld <= 1'b0;
        repeat (3 * cpb) @(posedge clk);
        // A strobe mid-transfer must be ignored
        cmd_in  <= ~stim[r].value;
        cmd_vld <= 1'b1;
        @(posedge clk);
        cmd_vld <= 1'b0;
        while (!cmd_rdy) @(posedge clk);
        repeat (2 * cpb) @(posedge clk);
      end else begin
        loop_sel <= 1'b0;
        send_frame(stim[r].value[7:0], stim[r].par_bad, stim[r].stop_bad);
        if (stim[r].stop_bad) begin
          repeat (2 * `UART_FRAME_BITS * cpb) @(posedge clk);
        end else begin
          repeat (2 * cpb) @(posedge clk);
        end
      end
      @(posedge clk);
      test_end <= 1'b1;
      @(posedge clk);
      test_end <= 1'b0;
    end
    @(posedge clk);
    $display("Tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && pass_cnt == rows) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+src
src/uart_cmd_pkg.sv
src/uart_cmd_split.sv
src/uart_tx_frame.sv
src/uart_rx_frame.sv
src/uart_cmd.sv
verification/uart_cmd_checker.sv
verification/uart_cmd_sva.sv
verification/uart_cmd_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and decide the result from the log
verilator --binary --timing --assert -f build.f --top-module uart_cmd_tb \
  -o uart_cmd_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/uart_cmd_sim > sim.log 2>&1
cat sim.log
grep -q -x "Simulation finished: PASS" sim.log && exit 0 || exit 1
